// ==== project.f ====
rtl/trs_io_pkg.sv
rtl/spi_slave.sv
rtl/cmd_parser.sv
rtl/cmd_exec.sv
rtl/breakpoint_unit.sv
rtl/trs_io_top.sv
sim/tb_trs_io_assertions.sv
sim/tb_trs_io.sv

// ==== rtl/breakpoint_unit.sv ====
/* breakpoint table with global enable, matched against cpu memory reads
   reports the lowest matching slot one cycle after the read */
`default_nettype none

module breakpoint_unit import trs_io_pkg::*; #(
  parameter int NUM_BP = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cmd_e                       cmd,
  input  logic [MAX_PARAMS-1:0][7:0] params,
  input  logic                       cmd_valid,
  input  logic [15:0]                trs_addr,
  input  logic                       trs_rd_n,
  output logic                       bp_hit,
  output logic [$clog2(NUM_BP)-1:0]  bp_index
);

  localparam int IDX_W = $clog2(NUM_BP);

  logic [15:0]      bp_addr [NUM_BP];
  logic [NUM_BP-1:0] bp_active;
  logic             bp_enabled;
  logic [IDX_W-1:0] slot;
  logic             match_any;
  logic [IDX_W-1:0] match_idx;

  assign slot = params[0][IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bp_active  <= '0;
      bp_enabled <= 1'b0;
    end else if (cmd_valid) begin
      case (cmd)
        set_breakpoint:      bp_active[slot] <= 1'b1;
        clear_breakpoint:    bp_active[slot] <= 1'b0;
        enable_breakpoints:  bp_enabled <= 1'b1;
        disable_breakpoints: bp_enabled <= 1'b0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd == set_breakpoint)
      bp_addr[slot] <= {params[2], params[1]}; // high byte in params[2]
  end

  // walk down so the lowest active match is left standing
  always_comb begin
    match_any = 1'b0;
    match_idx = '0;
    for (int i = NUM_BP - 1; i >= 0; i--) begin
      if (bp_active[i] && bp_addr[i] == trs_addr) begin
        match_any = 1'b1;
        match_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bp_hit   <= 1'b0;
      bp_index <= '0;
    end else begin
      bp_hit   <= match_any && bp_enabled && !trs_rd_n; // reads only
      bp_index <= match_idx;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cmd_exec.sv ====
/* runs parsed commands against the byte memory, keyboard matrix and colour reg
   answers cookie, version and peek with a one-cycle resp_valid pulse */
`default_nettype none

module cmd_exec import trs_io_pkg::*; #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cmd_e                       cmd,
  input  logic [MAX_PARAMS-1:0][7:0] params,
  input  logic                       cmd_valid,
  output logic [7:0]                 resp_byte,
  output logic                       resp_valid,
  output logic                       key_pressed,
  output logic [23:0]                screen_rgb
);

  localparam int ROW_W = $clog2(KEYB_ROWS);

  logic [7:0]            mem [2**MEM_ADDR_W];
  logic [15:0]           host_addr;  // params 1:0, little endian
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic [7:0]            mem_rd;
  logic                  peek_pend;  // read data arrives next cycle
  logic [7:0]            keyb [KEYB_ROWS];
  logic [ROW_W-1:0]      row;

  assign host_addr = {params[1], params[0]};
  assign mem_addr  = host_addr[MEM_ADDR_W-1:0]; // upper bits ignored
  assign row       = params[0][ROW_W-1:0];

  // single port memory, registered read
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd == bram_poke)
      mem[mem_addr] <= params[2];
    mem_rd <= mem[mem_addr];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      peek_pend  <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      peek_pend  <= cmd_valid && (cmd == bram_peek);
      resp_valid <= peek_pend ||
                    (cmd_valid && (cmd == get_cookie || cmd == get_version));
    end
  end

  always_ff @(posedge clk) begin
    if (peek_pend)
      resp_byte <= mem_rd;
    else if (cmd_valid && cmd == get_cookie)
      resp_byte <= COOKIE;
    else if (cmd_valid && cmd == get_version)
      resp_byte <= VERSION_BYTE;
  end

  // keyboard rows and screen colour
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < KEYB_ROWS; r++)
        keyb[r] <= '0;                // no keys down
      screen_rgb <= 24'hffffff;       // white until host sets it
    end else if (cmd_valid) begin
      if (cmd == send_keyb)
        keyb[row] <= params[1];
      if (cmd == set_screen_color)
        screen_rgb <= {params[0], params[1], params[2]}; // r, g, b
    end
  end

  always_comb begin
    key_pressed = 1'b0;
    for (int r = 0; r < KEYB_ROWS; r++)
      key_pressed = key_pressed | (|keyb[r]); // any bit in any row
  end

endmodule

`default_nettype wire

// ==== rtl/cmd_parser.sv ====
/* splits the received byte stream into opcode plus parameter bytes
   and pulses cmd_valid once a known command is complete */
`default_nettype none

module cmd_parser import trs_io_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [7:0]                   rx_byte,
  input  logic                         rx_valid,
  input  logic                         cs_active,
  output cmd_e                         cmd,
  output logic [MAX_PARAMS-1:0][7:0]   params,
  output logic                         cmd_valid
);

  parse_state_e      state;
  cmd_e              op;         // incoming byte seen as an opcode
  logic              op_known;
  logic [PCNT_W-1:0] op_nparams;
  logic [PCNT_W-1:0] remaining;  // param bytes still expected
  logic [PCNT_W-1:0] idx;        // slot for the next param byte

  assign op = cmd_e'(rx_byte);

  // parameter count per opcode
  always_comb begin
    op_known   = 1'b1;
    op_nparams = '0;
    case (op)
      get_cookie, get_version, enable_breakpoints, disable_breakpoints:
        op_nparams = PCNT_W'(0);
      clear_breakpoint:
        op_nparams = PCNT_W'(1);
      send_keyb:
        op_nparams = PCNT_W'(2);
      bram_poke, bram_peek, set_breakpoint, set_screen_color:
        op_nparams = PCNT_W'(3);
      default:
        op_known = 1'b0; // dropped, parser stays idle
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= idle;
      cmd_valid <= 1'b0;
      remaining <= '0;
      idx       <= '0;
    end else begin
      cmd_valid <= 1'b0;
      if (!cs_active) begin
        state <= idle; // cs released, partial command lost
      end else if (rx_valid) begin
        case (state)
          idle: begin
            if (op_known) begin
              remaining <= op_nparams;
              idx       <= '0;
              if (op_nparams == '0)
                cmd_valid <= 1'b1; // no params, run right away
              else
                state <= read_params;
            end
          end
          read_params: begin
            idx       <= idx + PCNT_W'(1);
            remaining <= remaining - PCNT_W'(1);
            if (remaining == PCNT_W'(1)) begin
              cmd_valid <= 1'b1; // last byte in
              state     <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // opcode and param bytes held until the next command overwrites them
  always_ff @(posedge clk) begin
    if (cs_active && rx_valid) begin
      if (state == idle && op_known)
        cmd <= op;
      if (state == read_params)
        params[idx] <= rx_byte;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spi_slave.sv ====
/* spi mode 0 slave, msb first, sampled on clk
   delivers received bytes as pulses and shifts out one loaded response byte */
`default_nettype none

module spi_slave (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       cs_active,
  input  logic [7:0] resp_byte,
  input  logic       resp_valid
);

  logic [2:0] sck_sync;  // [0] meets the async pin
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync; // lines up with sck_sync[1]
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      cs_sync   <= '1; // bus idle, cs released
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[2];

  // bit counter, cleared whenever cs is released
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_valid <= (bit_cnt == 3'd7); // eighth bit lands this edge
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
  end

  assign rx_byte = rx_shift; // stable for 16+ clk after rx_valid

  // response load wins over a coincident shift
  always_ff @(posedge clk) begin
    if (!rst_n)
      tx_shift <= '0;
    else if (resp_valid)
      tx_shift <= resp_byte;
    else if (cs_active && sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0}; // next bit ready before rising edge
  end

  assign miso = tx_shift[7];

endmodule

`default_nettype wire

// ==== rtl/trs_io_pkg.sv ====
/* opcodes, parser states and fixed reply bytes of the host command link
   imported by each rtl block that decodes or answers commands */
`default_nettype none

package trs_io_pkg;

  // host firmware numbering, gaps are commands this board no longer has
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    bram_poke           = 8'd1,
    bram_peek           = 8'd2,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    get_version         = 8'd15,
    set_screen_color    = 8'd17,
    send_keyb           = 8'd19
  } cmd_e;

  typedef enum logic {
    idle        = 1'b0, // waiting for an opcode byte
    read_params = 1'b1  // collecting parameter bytes
  } parse_state_e;

  localparam logic [7:0] COOKIE = 8'haf; // host probes for this byte

  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;
  localparam logic [7:0] VERSION_BYTE  = {VERSION_MAJOR, VERSION_MINOR};

  // longest command carries three bytes after the opcode
  localparam int MAX_PARAMS = 3;
  localparam int PCNT_W     = $clog2(MAX_PARAMS + 1); // holds 0..MAX_PARAMS

  localparam int KEYB_ROWS = 8; // rows of the keyboard matrix

endpackage

`default_nettype wire

// ==== rtl/trs_io_top.sv ====
/* fpga side of the i/o board, spi command link to the host mcu
   connects spi slave, parser, executor and breakpoint unit */
`default_nettype none

module trs_io_top import trs_io_pkg::*; #(
  parameter int MEM_ADDR_W = 10, // byte memory depth is 2**MEM_ADDR_W
  parameter int NUM_BP     = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sck,
  input  logic                      cs_n,
  input  logic                      mosi,
  output logic                      miso,
  input  logic [15:0]               trs_addr,
  input  logic                      trs_rd_n,
  output logic                      bp_hit,
  output logic [$clog2(NUM_BP)-1:0] bp_index,
  output logic                      key_pressed,
  output logic [23:0]               screen_rgb
);

  logic [7:0]                 rx_byte;
  logic                       rx_valid;   // one pulse per byte
  logic                       cs_active;
  cmd_e                       cmd;
  logic [MAX_PARAMS-1:0][7:0] params;
  logic                       cmd_valid;  // complete command
  logic [7:0]                 resp_byte;
  logic                       resp_valid; // loads spi transmit reg

  spi_slave i_spi (
    .clk(clk), .rst_n(rst_n),
    .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .rx_byte(rx_byte), .rx_valid(rx_valid), .cs_active(cs_active),
    .resp_byte(resp_byte), .resp_valid(resp_valid)
  );

  cmd_parser i_parser (
    .clk(clk), .rst_n(rst_n),
    .rx_byte(rx_byte), .rx_valid(rx_valid), .cs_active(cs_active),
    .cmd(cmd), .params(params), .cmd_valid(cmd_valid)
  );

  cmd_exec #(.MEM_ADDR_W(MEM_ADDR_W)) i_exec (
    .clk(clk), .rst_n(rst_n),
    .cmd(cmd), .params(params), .cmd_valid(cmd_valid),
    .resp_byte(resp_byte), .resp_valid(resp_valid),
    .key_pressed(key_pressed), .screen_rgb(screen_rgb)
  );

  breakpoint_unit #(.NUM_BP(NUM_BP)) i_bp (
    .clk(clk), .rst_n(rst_n),
    .cmd(cmd), .params(params), .cmd_valid(cmd_valid),
    .trs_addr(trs_addr), .trs_rd_n(trs_rd_n),
    .bp_hit(bp_hit), .bp_index(bp_index)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the testbench with verilator, runs it, then looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_trs_io -f project.f \
  -o tb_trs_io > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_trs_io +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim/tb_trs_io.sv ====
/* testbench for the i/o board, acts as spi host mcu and retro cpu bus
   shadow model predicts replies and status, a compare process checks them */
`default_nettype none

module tb_trs_io import trs_io_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_ADDR_W = 10;
  localparam int NUM_BP     = 8;
  localparam int SPI_HALF   = 8;  // clk per sck half period
  localparam int GAP        = 16; // sck low between frames, response needs 12
  localparam int SEED       = 57183;
  // about 240 spi bytes of 16 half periods, doubled for frame gaps
  localparam int TIMEOUT_CYC = 2 * 240 * 16 * SPI_HALF;

  logic clk = 1'b0;
  logic rst_n, sck, cs_n, mosi, miso, trs_rd_n;
  logic bp_hit, key_pressed;
  logic [15:0] trs_addr;
  logic [2:0]  bp_index;
  logic [23:0] screen_rgb;
  int errors = 0;
  int cycles = 0;

  // shadow state of the board
  logic [7:0]        mem_sh [2**MEM_ADDR_W];
  logic [15:0]       bp_addr_sh [NUM_BP];
  logic [NUM_BP-1:0] bp_act_sh = '0;
  logic              bp_en_sh = 1'b0;
  logic [7:0]        keyb_sh [8] = '{default: 8'h00};
  logic [23:0]       rgb_sh = 24'hffffff;

  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       what_q [$];

  trs_io_top #(.MEM_ADDR_W(MEM_ADDR_W), .NUM_BP(NUM_BP)) i_dut (
    .clk(clk), .rst_n(rst_n), .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .trs_addr(trs_addr), .trs_rd_n(trs_rd_n), .bp_hit(bp_hit), .bp_index(bp_index),
    .key_pressed(key_pressed), .screen_rgb(screen_rgb)
  );

  always #2 clk = ~clk; // 4 ns period

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  always @(negedge clk) begin
    if (got_q.size() != 0)
      check(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
  end

  task automatic post(input logic [31:0] got, input logic [31:0] exp, input string what);
    got_q.push_back(got);
    exp_q.push_back(exp);
    what_q.push_back(what);
  endtask

  // reference model, updates the shadows and returns the expected reply byte
  function automatic logic [7:0] model_cmd(input cmd_e op, input logic [7:0] p0,
                                           input logic [7:0] p1, input logic [7:0] p2);
    logic [7:0] resp;
    logic [MEM_ADDR_W-1:0] a;
    resp = 8'h00;
    a = MEM_ADDR_W'({p1, p0}); // upper address bits fall away
    case (op)
      get_cookie:          resp = 8'haf;
      get_version:         resp = {3'd0, 5'd3};
      bram_poke:           mem_sh[a] = p2;
      bram_peek:           resp = mem_sh[a];
      set_breakpoint: begin
        bp_addr_sh[p0[2:0]] = {p2, p1};
        bp_act_sh[p0[2:0]] = 1'b1;
      end
      clear_breakpoint:    bp_act_sh[p0[2:0]] = 1'b0;
      enable_breakpoints:  bp_en_sh = 1'b1;
      disable_breakpoints: bp_en_sh = 1'b0;
      set_screen_color:    rgb_sh = {p0, p1, p2};
      send_keyb:           keyb_sh[p0[2:0]] = p1;
      default: ;
    endcase
    return resp;
  endfunction

  function automatic logic any_key();
    logic k;
    k = 1'b0;
    for (int r = 0; r < 8; r++)
      k = k | (|keyb_sh[r]);
    return k;
  endfunction

  // {hit, slot}, lowest active slot wins
  function automatic logic [3:0] expect_hit(input logic [15:0] addr, input logic rd_n);
    logic [3:0] res;
    res = 4'h0;
    for (int i = 0; i < NUM_BP; i++)
      if (bp_en_sh && !rd_n && bp_act_sh[i] && bp_addr_sh[i] == addr && !res[3])
        res = {1'b1, 3'(i)};
    return res;
  endfunction

  function automatic int param_count(input cmd_e op);
    case (op)
      clear_breakpoint: return 1;
      send_keyb:        return 2;
      bram_poke, bram_peek, set_breakpoint, set_screen_color: return 3;
      default:          return 0;
    endcase
  endfunction

  // one mode 0 byte, entered and left on a rising clk edge
  task automatic spi_byte(input logic [7:0] tx, input logic last, output logic [7:0] rx);
    for (int b = 7; b >= 0; b--) begin
      mosi <= tx[b];
      repeat (SPI_HALF - 1) @(posedge clk);
      @(negedge clk);
      rx[b] = miso; // host samples just before the rise
      @(posedge clk);
      sck <= 1'b1;
      repeat (SPI_HALF) @(posedge clk);
      if (last && b == 0) begin
        cs_n <= 1'b1; // release cs first, the last fall must not shift tx
        @(posedge clk);
      end
      sck <= 1'b0;
    end
  endtask

  task automatic send_cmd(input cmd_e op, input logic [7:0] p0, input logic [7:0] p1,
                          input logic [7:0] p2, input int nbytes);
    logic [7:0] p [3];
    logic [7:0] dummy;
    p[0] = p0;
    p[1] = p1;
    p[2] = p2;
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (SPI_HALF) @(posedge clk);
    spi_byte(op, nbytes == 0, dummy);
    for (int i = 0; i < nbytes; i++)
      spi_byte(p[i], i == nbytes - 1, dummy);
    repeat (GAP) @(posedge clk);
  endtask

  task automatic read_resp(output logic [7:0] r);
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (SPI_HALF) @(posedge clk);
    spi_byte(8'hff, 1'b1, r); // 0xff is no opcode
    repeat (GAP) @(posedge clk);
  endtask

  task automatic do_cmd(input cmd_e op, input logic [7:0] p0, input logic [7:0] p1,
                        input logic [7:0] p2);
    logic [7:0] exp;
    logic [7:0] got;
    exp = model_cmd(op, p0, p1, p2);
    send_cmd(op, p0, p1, p2, param_count(op));
    if (op == get_cookie || op == get_version || op == bram_peek) begin
      read_resp(got);
      post(32'(got), 32'(exp), $sformatf("reply to opcode %0d", op));
    end
    post(32'(screen_rgb), 32'(rgb_sh), "screen_rgb");
    post(32'(key_pressed), 32'(any_key()), "key_pressed");
  endtask

  // one cpu bus cycle, hit is checked one clk later
  task automatic bus_access(input logic [15:0] addr, input logic rd_n);
    @(posedge clk);
    trs_addr <= addr;
    trs_rd_n <= rd_n;
    @(posedge clk);
    trs_rd_n <= 1'b1;
    @(negedge clk);
    post(32'({bp_hit, bp_hit ? bp_index : 3'd0}), 32'(expect_hit(addr, rd_n)),
         $sformatf("breakpoint for %h rd_n %b", addr, rd_n));
  endtask

  initial begin
    logic [15:0] addrs [20];
    void'($urandom(SEED));
    rst_n = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    trs_addr = 16'h0000;
    trs_rd_n = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    post(32'(screen_rgb), 32'h00ffffff, "screen_rgb after reset");
    post(32'({key_pressed, bp_hit, miso}), 32'h0, "status after reset");

    do_cmd(get_cookie, 8'h00, 8'h00, 8'h00);
    do_cmd(get_version, 8'h00, 8'h00, 8'h00);

    for (int i = 0; i < 20; i++) begin
      addrs[i] = 16'($urandom);
      do_cmd(bram_poke, addrs[i][7:0], addrs[i][15:8], 8'($urandom));
    end
    for (int i = 0; i < 20; i++)
      do_cmd(bram_peek, addrs[i][7:0], addrs[i][15:8], 8'h00);

    do_cmd(set_screen_color, 8'($urandom), 8'($urandom), 8'($urandom));
    do_cmd(send_keyb, 8'd3, 8'h10, 8'h00);
    do_cmd(send_keyb, 8'd6, 8'h81, 8'h00);
    do_cmd(send_keyb, 8'd3, 8'h00, 8'h00);
    do_cmd(send_keyb, 8'd6, 8'h00, 8'h00); // all rows clear again

    do_cmd(set_breakpoint, 8'd2, 8'h34, 8'h12);
    bus_access(16'h1234, 1'b0);           // table still disabled
    do_cmd(enable_breakpoints, 8'h00, 8'h00, 8'h00);
    bus_access(16'h1234, 1'b0);
    bus_access(16'h1234, 1'b1);           // write cycle
    bus_access(16'h1235, 1'b0);
    do_cmd(set_breakpoint, 8'd5, 8'h34, 8'h12);
    do_cmd(set_breakpoint, 8'd1, 8'h34, 8'h12);
    bus_access(16'h1234, 1'b0);           // slots 1, 2, 5 all match
    do_cmd(clear_breakpoint, 8'd1, 8'h00, 8'h00);
    bus_access(16'h1234, 1'b0);
    do_cmd(disable_breakpoints, 8'h00, 8'h00, 8'h00);
    bus_access(16'h1234, 1'b0);
    do_cmd(enable_breakpoints, 8'h00, 8'h00, 8'h00);
    do_cmd(clear_breakpoint, 8'd2, 8'h00, 8'h00);
    do_cmd(clear_breakpoint, 8'd5, 8'h00, 8'h00);
    bus_access(16'h1234, 1'b0);

    // poke cut off after its first param byte, memory keeps the old value
    send_cmd(bram_poke, addrs[0][7:0], addrs[0][15:8], 8'h5a, 1);
    do_cmd(bram_peek, addrs[0][7:0], addrs[0][15:8], 8'h00);

    while (got_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    $display("Finished with %0d errors and %0d assertion failures",
             errors, i_dut.i_assert.fails);
    if (errors == 0 && i_dut.i_assert.fails == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_trs_io_assertions.sv ====
/* timing rules of the command path and breakpoint port
   bound into every trs_io_top instance */
`default_nettype none

module tb_trs_io_assertions (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic cmd_valid,
  input wire logic resp_valid,
  input wire logic cs_active,
  input wire logic trs_rd_n,
  input wire logic bp_hit
);
  timeunit 1ns;
  timeprecision 100ps;

  int fails = 0;

  // cookie and version answer after 1 cycle, peek after 2
  resp_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> ($past(cmd_valid, 1) || $past(cmd_valid, 2)))
    else begin
      $error("resp_valid without a command one or two cycles before");
      fails++;
    end

  hit_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
    bp_hit |-> $past(!trs_rd_n)) // writes never hit
    else begin
      $error("bp_hit without a cpu read in the cycle before");
      fails++;
    end

  cmd_inside_cs: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid |-> cs_active)
    else begin
      $error("cmd_valid while cs was released");
      fails++;
    end

endmodule

bind trs_io_top tb_trs_io_assertions i_assert (
  .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .resp_valid(resp_valid),
  .cs_active(cs_active), .trs_rd_n(trs_rd_n), .bp_hit(bp_hit)
);

`default_nettype wire
